/* logic/window_pkg.sv */
// Shared widths for the windowing engine
// Sample and product structs, settings data union
`default_nettype none

package window_pkg;

  // Component and coefficient widths, coefficients are Q1.15
  localparam int SAMPLE_WIDTH = 16;
  localparam int COEFF_WIDTH = 16;
  localparam int PRODUCT_WIDTH = 32;
  localparam int SETTINGS_WIDTH = 32;
  localparam int WINDOW_LEN_WIDTH = 13;

  // One complex sample, I in the upper half of the data image
  typedef struct packed {
    logic signed [SAMPLE_WIDTH-1:0] i;
    logic signed [SAMPLE_WIDTH-1:0] q;
    logic last;
  } window_sample_t;

  // Full precision products ahead of rounding
  typedef struct packed {
    logic signed [PRODUCT_WIDTH-1:0] i_prod;
    logic signed [PRODUCT_WIDTH-1:0] q_prod;
    logic last;
  } window_product_t;

  typedef struct packed {
    logic [SETTINGS_WIDTH-WINDOW_LEN_WIDTH-1:0] reserved;
    logic [WINDOW_LEN_WIDTH-1:0] length;
  } settings_length_t;

  typedef struct packed {
    logic [SETTINGS_WIDTH-COEFF_WIDTH-1:0] reserved;
    logic signed [COEFF_WIDTH-1:0] coeff;
  } settings_coeff_t;

  // Same data word, meaning picked by the settings address
  typedef union packed {
    settings_length_t len_view;
    settings_coeff_t coeff_view;
  } settings_word_u;

endpackage

`default_nettype wire

/* logic/window_settings_decode.sv */
// Settings bus decode for window length and coefficient loading
`timescale 1ns/100ps
`default_nettype none

module window_settings_decode #(
  parameter int MAX_LOG2_WINDOW = 12,
  parameter logic [7:0] SR_WINDOW_SIZE = 8'd131,
  parameter logic [7:0] SR_COEFF = 8'd129
) (
  input  wire logic ce_clk,
  input  wire logic i_reset,
  input  wire logic i_set_stb,
  input  wire logic [7:0] i_set_addr,
  input  wire logic [window_pkg::SETTINGS_WIDTH-1:0] i_set_data,
  output logic o_coeff_we,
  output logic [MAX_LOG2_WINDOW-1:0] o_coeff_waddr,
  output logic signed [window_pkg::COEFF_WIDTH-1:0] o_coeff_wdata,
  output logic [MAX_LOG2_WINDOW-1:0] o_window_last_index,
  output logic o_restart
);
  import window_pkg::*;

  localparam logic [WINDOW_LEN_WIDTH-1:0] MAX_LEN = WINDOW_LEN_WIDTH'(2**MAX_LOG2_WINDOW);
  localparam logic [MAX_LOG2_WINDOW-1:0] MAX_LAST_INDEX = '1;

  settings_word_u set_word;
  logic [WINDOW_LEN_WIDTH-1:0] req_len;
  logic [WINDOW_LEN_WIDTH-1:0] req_len_m1;
  logic [MAX_LOG2_WINDOW-1:0] clamped_last;
  logic [MAX_LOG2_WINDOW-1:0] write_ptr;

  assign set_word = i_set_data;
  assign req_len = set_word.len_view.length;
  assign req_len_m1 = req_len - 1'b1;

  // Zero or oversized lengths fall back to the full table
  assign clamped_last = (req_len == '0 || req_len > MAX_LEN) ? MAX_LAST_INDEX :
                        req_len_m1[MAX_LOG2_WINDOW-1:0];

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      write_ptr <= '0;
      o_coeff_we <= 1'b0;
      o_restart <= 1'b0;
      o_window_last_index <= MAX_LAST_INDEX;
    end else begin
      o_coeff_we <= 1'b0;
      o_restart <= 1'b0;
      if (i_set_stb && i_set_addr == SR_WINDOW_SIZE) begin
        o_window_last_index <= clamped_last;
        write_ptr <= '0;
        o_restart <= 1'b1;
      end else if (i_set_stb && i_set_addr == SR_COEFF) begin
        o_coeff_we <= 1'b1;
        // Wraps past the end of the table
        write_ptr <= write_ptr + 1'b1;
      end
    end
  end

  // Write port payload
  always_ff @(posedge ce_clk) begin
    if (i_set_stb && i_set_addr == SR_COEFF) begin
      o_coeff_waddr <= write_ptr;
      o_coeff_wdata <= set_word.coeff_view.coeff;
    end
  end

endmodule

`default_nettype wire

/* logic/window_coeff_table.sv */
// Window coefficient memory
// One write port, registered read with enable
`timescale 1ns/100ps
`default_nettype none

module window_coeff_table #(
  parameter int MAX_LOG2_WINDOW = 12
) (
  input  wire logic ce_clk,
  input  wire logic i_we,
  input  wire logic [MAX_LOG2_WINDOW-1:0] i_waddr,
  input  wire logic signed [window_pkg::COEFF_WIDTH-1:0] i_wdata,
  input  wire logic [MAX_LOG2_WINDOW-1:0] i_raddr,
  input  wire logic i_rd_en,
  output logic signed [window_pkg::COEFF_WIDTH-1:0] o_rdata
);
  import window_pkg::*;

  localparam int DEPTH = 2**MAX_LOG2_WINDOW;

  logic signed [COEFF_WIDTH-1:0] mem [DEPTH];

  ////////////////////////////////////////
  // Write side
  ////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  // Read data holds while the pipeline stalls
  always_ff @(posedge ce_clk) begin
    if (i_rd_en) begin
      o_rdata <= mem[i_raddr];
    end
  end

endmodule

`default_nettype wire

/* logic/window_multiply.sv */
// Coefficient index tracking, table read issue and the I/Q multiply
// Two pipeline stages, both held while advance is low
`timescale 1ns/100ps
`default_nettype none

module window_multiply #(
  parameter int MAX_LOG2_WINDOW = 12
) (
  input  wire logic ce_clk,
  input  wire logic i_reset,
  input  wire window_pkg::window_sample_t i_sample,
  input  wire logic i_valid,
  input  wire logic i_advance,
  input  wire logic [MAX_LOG2_WINDOW-1:0] i_window_last_index,
  input  wire logic i_restart,
  output logic [MAX_LOG2_WINDOW-1:0] o_raddr,
  output logic o_rd_en,
  input  wire logic signed [window_pkg::COEFF_WIDTH-1:0] i_coeff,
  output window_pkg::window_product_t o_product,
  output logic o_valid
);
  import window_pkg::*;

  logic [MAX_LOG2_WINDOW-1:0] coeff_index;
  logic accept;
  logic index_wrap;
  window_sample_t read_sample;
  logic read_valid;

  assign accept = i_valid && i_advance;

  // Wrap on last sample of a packet or end of window
  assign index_wrap = i_sample.last || (coeff_index >= i_window_last_index);

  ////////////////////////////////////////
  // Index and table read
  ////////////////////////////////////////
  assign o_raddr = coeff_index;
  assign o_rd_en = i_advance;

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      coeff_index <= '0;
    end else if (i_restart) begin
      coeff_index <= '0;
    end else if (accept) begin
      if (index_wrap) begin
        coeff_index <= '0;
      end else begin
        coeff_index <= coeff_index + 1'b1;
      end
    end
  end

  // Sample rides alongside the table read
  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      read_valid <= 1'b0;
    end else if (i_advance) begin
      read_valid <= i_valid;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (accept) begin
      read_sample <= i_sample;
    end
  end

  ////////////////////////////////////////
  // Multiply
  ////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else if (i_advance) begin
      o_valid <= read_valid;
    end
  end

  // Full width signed products, Q1.15 coefficient
  always_ff @(posedge ce_clk) begin
    if (i_advance && read_valid) begin
      o_product.i_prod <= read_sample.i * i_coeff;
      o_product.q_prod <= read_sample.q * i_coeff;
      o_product.last <= read_sample.last;
    end
  end

endmodule

`default_nettype wire

/* logic/window_round_pack.sv */
// Round and saturate products to 16 bits
// Output register and the pipeline advance signal
`timescale 1ns/100ps
`default_nettype none

module window_round_pack (
  input  wire logic ce_clk,
  input  wire logic i_reset,
  input  wire window_pkg::window_product_t i_product,
  input  wire logic i_valid,
  input  wire logic i_ready,
  output window_pkg::window_sample_t o_sample,
  output logic o_valid,
  output logic o_advance
);
  import window_pkg::*;

  localparam logic signed [PRODUCT_WIDTH-1:0] ROUND_HALF = 1 << (COEFF_WIDTH-2);
  localparam logic signed [PRODUCT_WIDTH-1:0] SAT_MAX = 2**(SAMPLE_WIDTH-1) - 1;
  localparam logic signed [PRODUCT_WIDTH-1:0] SAT_MIN = -(2**(SAMPLE_WIDTH-1));

  // Round half up, drop the Q1.15 fraction, clip to 16 bits
  function automatic logic signed [SAMPLE_WIDTH-1:0] round_sat(
    input logic signed [PRODUCT_WIDTH-1:0] prod
  );
    logic signed [PRODUCT_WIDTH-1:0] shifted;
    shifted = (prod + ROUND_HALF) >>> (COEFF_WIDTH-1);
    if (shifted > SAT_MAX) begin
      return SAT_MAX[SAMPLE_WIDTH-1:0];
    end else if (shifted < SAT_MIN) begin
      return SAT_MIN[SAMPLE_WIDTH-1:0];
    end
    return shifted[SAMPLE_WIDTH-1:0];
  endfunction

  // Empty or draining output register lets everything move
  assign o_advance = !o_valid || i_ready;

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else if (o_advance) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (o_advance && i_valid) begin
      o_sample.i <= round_sat(i_product.i_prod);
      o_sample.q <= round_sat(i_product.q_prod);
      o_sample.last <= i_product.last;
    end
  end

endmodule

`default_nettype wire

/* logic/window_core.sv */
// Windowing engine top level
// Settings decode, coefficient table, multiply and round stages
`timescale 1ns/100ps
`default_nettype none

module window_core #(
  parameter int MAX_LOG2_WINDOW = 12,
  parameter logic [7:0] SR_WINDOW_SIZE = 8'd131,
  parameter logic [7:0] SR_COEFF = 8'd129
) (
  input  wire logic ce_clk,
  input  wire logic i_reset,
  input  wire logic i_set_stb,
  input  wire logic [7:0] i_set_addr,
  input  wire logic [window_pkg::SETTINGS_WIDTH-1:0] i_set_data,
  input  wire logic [2*window_pkg::SAMPLE_WIDTH-1:0] i_tdata,
  input  wire logic i_tlast,
  input  wire logic i_tvalid,
  output logic o_tready,
  output logic [2*window_pkg::SAMPLE_WIDTH-1:0] o_tdata,
  output logic o_tlast,
  output logic o_tvalid,
  input  wire logic i_tready
);
  import window_pkg::*;

  logic coeff_we;
  logic [MAX_LOG2_WINDOW-1:0] coeff_waddr;
  logic signed [COEFF_WIDTH-1:0] coeff_wdata;
  logic [MAX_LOG2_WINDOW-1:0] window_last_index;
  logic restart;
  logic [MAX_LOG2_WINDOW-1:0] coeff_raddr;
  logic coeff_rd_en;
  logic signed [COEFF_WIDTH-1:0] coeff_rdata;
  window_sample_t in_sample;
  window_sample_t out_sample;
  window_product_t product;
  logic product_valid;
  logic advance;

  // Flat stream ports to structs, I in the upper half
  assign in_sample.i = i_tdata[2*SAMPLE_WIDTH-1:SAMPLE_WIDTH];
  assign in_sample.q = i_tdata[SAMPLE_WIDTH-1:0];
  assign in_sample.last = i_tlast;
  assign o_tdata = {out_sample.i, out_sample.q};
  assign o_tlast = out_sample.last;
  assign o_tready = advance;

  window_settings_decode #(
    .MAX_LOG2_WINDOW(MAX_LOG2_WINDOW),
    .SR_WINDOW_SIZE(SR_WINDOW_SIZE),
    .SR_COEFF(SR_COEFF)
  ) u_decode (
    .ce_clk(ce_clk), .i_reset(i_reset),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .o_coeff_we(coeff_we), .o_coeff_waddr(coeff_waddr), .o_coeff_wdata(coeff_wdata),
    .o_window_last_index(window_last_index), .o_restart(restart)
  );

  window_coeff_table #(.MAX_LOG2_WINDOW(MAX_LOG2_WINDOW)) u_table (
    .ce_clk(ce_clk),
    .i_we(coeff_we), .i_waddr(coeff_waddr), .i_wdata(coeff_wdata),
    .i_raddr(coeff_raddr), .i_rd_en(coeff_rd_en), .o_rdata(coeff_rdata)
  );

  window_multiply #(.MAX_LOG2_WINDOW(MAX_LOG2_WINDOW)) u_execute (
    .ce_clk(ce_clk), .i_reset(i_reset),
    .i_sample(in_sample), .i_valid(i_tvalid), .i_advance(advance),
    .i_window_last_index(window_last_index), .i_restart(restart),
    .o_raddr(coeff_raddr), .o_rd_en(coeff_rd_en), .i_coeff(coeff_rdata),
    .o_product(product), .o_valid(product_valid)
  );

  window_round_pack u_result (
    .ce_clk(ce_clk), .i_reset(i_reset),
    .i_product(product), .i_valid(product_valid), .i_ready(i_tready),
    .o_sample(out_sample), .o_valid(o_tvalid), .o_advance(advance)
  );

endmodule

`default_nettype wire

/* verification/window_core_assert.sv */
// Stream handshake and reset assertions, bound into the windowing top level
`timescale 1ns/100ps
`default_nettype none

module window_core_assert (
  input wire logic ce_clk,
  input wire logic i_reset,
  input wire logic [2*window_pkg::SAMPLE_WIDTH-1:0] o_tdata,
  input wire logic o_tlast,
  input wire logic o_tvalid,
  input wire logic o_tready,
  input wire logic i_tready
);

  // Output register is cleared by the synchronous reset
  reset_clears_valid: assert property (@(posedge ce_clk) i_reset |=> !o_tvalid)
    else $error("o_tvalid high after a reset cycle");

  // Stalled output keeps its payload
  stalled_output_stable: assert property (@(posedge ce_clk) disable iff (i_reset)
    o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata) && $stable(o_tlast))
    else $error("o_tdata or o_tlast changed while stalled");

  // Empty output register always accepts
  ready_when_empty: assert property (@(posedge ce_clk) disable iff (i_reset)
    !o_tvalid |-> o_tready)
    else $error("o_tready low with the output register empty");

endmodule

bind window_core window_core_assert u_assert (
  .ce_clk(ce_clk), .i_reset(i_reset),
  .o_tdata(o_tdata), .o_tlast(o_tlast), .o_tvalid(o_tvalid),
  .o_tready(o_tready), .i_tready(i_tready)
);

`default_nettype wire

/* verification/window_core_tb.sv */
// Testbench for the windowing engine
// Random settings and stream stimulus, reference model and output checker
`timescale 1ns/100ps
`default_nettype none

module window_core_tb;
  import window_pkg::*;

  localparam int MAX_LOG2_WINDOW = 12;
  localparam int DEPTH = 2**MAX_LOG2_WINDOW;
  localparam logic [7:0] SR_WINDOW_SIZE = 8'd131;
  localparam logic [7:0] SR_COEFF = 8'd129;
  localparam int TIMEOUT = 1000;

  logic ce_clk;
  logic i_reset;
  logic i_set_stb;
  logic [7:0] i_set_addr;
  logic [31:0] i_set_data;
  logic [2*SAMPLE_WIDTH-1:0] i_tdata;
  logic i_tlast;
  logic i_tvalid;
  logic o_tready;
  logic [2*SAMPLE_WIDTH-1:0] o_tdata;
  logic o_tlast;
  logic o_tvalid;
  logic i_tready;

  integer seed;
  logic bp_enable;
  logic [31:0] rnd_bp;
  int errors;
  int checks;
  int cycle;

  // Reference model state
  logic signed [COEFF_WIDTH-1:0] model_coeff [DEPTH];
  int model_len;
  int model_index;
  int model_wptr;
  logic [32:0] exp_q [$];
  int cyc_q [$];
  logic [15:0] edge_vals [6] = '{16'h8000, 16'h8001, 16'hffff, 16'h0000, 16'h0001, 16'h7fff};
  int short_lens [3] = '{1, 5, 17};

  window_core #(
    .MAX_LOG2_WINDOW(MAX_LOG2_WINDOW),
    .SR_WINDOW_SIZE(SR_WINDOW_SIZE),
    .SR_COEFF(SR_COEFF)
  ) dut (
    .ce_clk(ce_clk), .i_reset(i_reset),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_tdata(i_tdata), .i_tlast(i_tlast), .i_tvalid(i_tvalid), .o_tready(o_tready),
    .o_tdata(o_tdata), .o_tlast(o_tlast), .o_tvalid(o_tvalid), .i_tready(i_tready)
  );

  initial begin
    ce_clk = 1'b0;
    forever #4 ce_clk = ~ce_clk;
  end

  task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                             input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, expected);
    end
  endtask

  task automatic end_run_on_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Errors found");
    $finish;
  endtask

  // Q1.15 multiply, round half up, clip to 16 bits
  function automatic logic [15:0] round_to_sample(input logic signed [15:0] x,
                                                  input logic signed [15:0] c);
    longint p;
    longint r;
    p = longint'(x) * longint'(c);
    r = (p + 16384) >>> 15;
    if (r > 32767) r = 32767;
    else if (r < -32768) r = -32768;
    return r[15:0];
  endfunction

  function automatic logic [32:0] make_expected(input logic [31:0] data, input logic last,
                                                input logic signed [15:0] coeff);
    return {round_to_sample(data[31:16], coeff), round_to_sample(data[15:0], coeff), last};
  endfunction

  ////////////////////////////////////////
  // Settings and stream drivers
  ////////////////////////////////////////
  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    int len;
    i_set_stb <= 1'b1;
    i_set_addr <= addr;
    i_set_data <= data;
    if (addr == SR_WINDOW_SIZE) begin
      len = int'(data[12:0]);
      model_len = (len == 0 || len > DEPTH) ? DEPTH : len;
      model_index = 0;
      model_wptr = 0;
    end else if (addr == SR_COEFF) begin
      model_coeff[model_wptr] = data[15:0];
      model_wptr = (model_wptr + 1) % DEPTH;
    end
    @(posedge ce_clk);
  endtask

  task automatic end_settings();
    i_set_stb <= 1'b0;
    repeat (4) @(posedge ce_clk);
  endtask

  task automatic send_sample(input logic [31:0] data, input logic last);
    int waited;
    i_tdata <= data;
    i_tlast <= last;
    i_tvalid <= 1'b1;
    waited = 0;
    @(posedge ce_clk);
    while (!o_tready) begin
      waited++;
      if (waited > TIMEOUT) end_run_on_timeout("input sample was never accepted");
      @(posedge ce_clk);
    end
  endtask

  // Random data, optional random tlast and idle gaps
  task automatic send_stream(input int count, input bit with_last, input bit with_gaps);
    logic [31:0] r;
    for (int k = 0; k < count; k++) begin
      r = $random(seed);
      if (with_gaps && r[1:0] == 2'd0) begin
        i_tvalid <= 1'b0;
        @(posedge ce_clk);
      end
      send_sample($random(seed), with_last && r[6:4] == 3'd0);
    end
    i_tvalid <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) end_run_on_timeout("output stream never drained");
      @(posedge ce_clk);
    end
  endtask

  task automatic load_table(input int length, input int count);
    write_setting(SR_WINDOW_SIZE, length);
    for (int k = 0; k < count; k++) begin
      write_setting(SR_COEFF, $random(seed));
    end
    end_settings();
  endtask

  // Sink back-pressure
  always @(posedge ce_clk) begin
    if (bp_enable) begin
      rnd_bp = $random(seed);
      i_tready <= rnd_bp[0] | rnd_bp[1];
    end else begin
      i_tready <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Model update and output compare
  ////////////////////////////////////////
  always @(posedge ce_clk) begin : monitor
    logic [32:0] got;
    int accept_cycle;
    if (!i_reset && i_tvalid && o_tready) begin
      exp_q.push_back(make_expected(i_tdata, i_tlast, model_coeff[model_index]));
      cyc_q.push_back(bp_enable ? -1 : cycle);
      if (i_tlast || model_index >= model_len - 1) model_index = 0;
      else model_index++;
    end
    if (!i_reset && o_tvalid && i_tready) begin
      got = {o_tdata, o_tlast};
      if (exp_q.size() == 0) begin
        errors++;
        $display("Output sample at %0t has no matching input sample", $time);
      end else begin
        check_value(64'(got), 64'(exp_q.pop_front()), "output sample");
        accept_cycle = cyc_q.pop_front();
        if (accept_cycle >= 0) check_value(64'(cycle - accept_cycle), 64'd3, "latency");
      end
    end
    cycle++;
  end

  initial begin
    seed = 32'hbaa5;
    errors = 0;
    checks = 0;
    cycle = 0;
    model_len = DEPTH;
    model_index = 0;
    model_wptr = 0;
    bp_enable = 1'b0;
    i_reset = 1'b1;
    i_set_stb = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_tdata = '0;
    i_tlast = 1'b0;
    i_tvalid = 1'b0;
    i_tready = 1'b1;
    repeat (3) @(posedge ce_clk);
    i_reset <= 1'b0;
    @(posedge ce_clk);
    check_value(64'(o_tvalid), 64'd0, "o_tvalid after reset");
    check_value(64'(o_tready), 64'd1, "o_tready after reset");

    // Free running stream over a full random table
    load_table(DEPTH, DEPTH);
    send_stream(300, 1'b0, 1'b0);
    wait_drain();

    // Short windows repeat the coefficient sequence
    foreach (short_lens[n]) begin
      load_table(short_lens[n], 0);
      send_stream(60, 1'b0, 1'b1);
      wait_drain();
    end

    // Packets shorter than the window
    load_table(32, 0);
    send_stream(200, 1'b1, 1'b1);
    wait_drain();

    // Sink back-pressure
    load_table(64, 0);
    bp_enable <= 1'b1;
    send_stream(400, 1'b1, 1'b1);
    wait_drain();
    bp_enable <= 1'b0;

    // Each edge pair against both extreme coefficients
    write_setting(SR_WINDOW_SIZE, 32'd2);
    write_setting(SR_COEFF, 32'h0000_8000);
    write_setting(SR_COEFF, 32'h0000_7fff);
    end_settings();
    foreach (edge_vals[a]) begin
      foreach (edge_vals[b]) begin
        repeat (2) send_sample({edge_vals[a], edge_vals[b]}, 1'b0);
      end
    end
    i_tvalid <= 1'b0;
    wait_drain();

    // Reload from entry 0 and then a zero length as the full table
    load_table(8, 8);
    send_stream(40, 1'b0, 1'b1);
    wait_drain();
    load_table(0, 3);
    send_stream(DEPTH + 20, 1'b0, 1'b0);
    wait_drain();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* window_core.f */
logic/window_pkg.sv
logic/window_settings_decode.sv
logic/window_coeff_table.sv
logic/window_multiply.sv
logic/window_round_pack.sv
logic/window_core.sv
verification/window_core_assert.sv
verification/window_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the windowing engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module window_core_tb \
  -f window_core.f \
  -o window_core_sim

if ! ./obj_dir/window_core_sim > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error status"
  exit 1
fi
cat sim.log

if grep -qx "No errors" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
